// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" && \
  verilator --binary --timing --top-module tb_rename_core -f src.f && \
  ./obj_dir/Vtb_rename_core | tee /dev/stderr | grep -q "Simulation finished: PASS" && \
  echo "Testbench run passed" || \
  { echo "Testbench run failed"; exit 1; }

// ==== sim/tb_rename_core.sv ====
// Random-stimulus testbench for rename_core, checked against a model of map, free list and registers

`timescale 1ns/1ps

module tb_rename_core
  import rename_pkg::*;
();

  localparam int          READ_PORTS  = 2;
  localparam int          TEST_CYCLES = 720;
  localparam int          TIMEOUT_NS  = TEST_CYCLES * 100 + 10000;
  localparam logic [31:0] SEED        = 32'h87cb_c7dc;

  // ==================================================
  // DUT signals
  // ==================================================

  logic                                  clk;
  logic                                  rst_n;
  logic                                  rename_valid;
  rename_req_t                           rename_req;
  logic                                  rename_stall;
  logic                                  renamed_valid;
  renamed_t                              renamed;
  logic                                  commit_valid;
  logic [PREG_W-1:0]                     commit_prd;
  logic                                  wb_valid;
  wb_t                                   wb;
  logic [READ_PORTS-1:0]                 rd_en;
  logic [READ_PORTS-1:0][PREG_W-1:0]     rd_addr;
  logic [READ_PORTS-1:0][DATA_WIDTH-1:0] rd_data;

  // ==================================================
  // Reference model state
  // ==================================================

  logic [PREG_W-1:0]     map_m [ARCH_REG_NUM];
  logic [PREG_W-1:0]     free_q [$];
  // Superseded tags waiting for retirement
  logic [PREG_W-1:0]     commit_q [$];
  logic [DATA_WIDTH-1:0] regs_m [PHY_REG_NUM];
  bit                    written_m [PHY_REG_NUM];

  // Expected renamed output for the next cycle
  logic        exp_valid;
  renamed_t    exp_out;
  // Stalled request must stay on the bus
  logic        hold_req;
  logic        dir_pending;
  rename_req_t dir_req;

  int errors;
  int stall_cycles;
  int bypass_hits;

  rename_core #(
    .READ_PORT_NUM (READ_PORTS)
  ) u_rename_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .rename_valid_i  (rename_valid),
    .rename_req_i    (rename_req),
    .rename_stall_o  (rename_stall),
    .renamed_valid_o (renamed_valid),
    .renamed_o       (renamed),
    .commit_valid_i  (commit_valid),
    .commit_prd_i    (commit_prd),
    .wb_valid_i      (wb_valid),
    .wb_i            (wb),
    .rd_en_i         (rd_en),
    .rd_addr_i       (rd_addr),
    .rd_data_o       (rd_data)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ==================================================
  // Helpers
  // ==================================================

  // ALU and load own a destination
  function automatic logic is_dest_op(op_e op);
    return (op == OP_ALU) || (op == OP_LOAD);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  task automatic queue_directed(input op_e op, input logic [AREG_W-1:0] rd,
                                input logic [AREG_W-1:0] rs1, input logic [AREG_W-1:0] rs2);
    dir_req.op  = op;
    dir_req.rd  = rd;
    dir_req.rs1 = rs1;
    dir_req.rs2 = rs2;
    dir_pending = 1'b1;
  endtask

  // Registered outputs, stable since the rising edge
  task automatic check_renamed_out();
    check_value("renamed_valid_o", 64'(renamed_valid), 64'(exp_valid));
    if (exp_valid) begin
      check_value("renamed_o.op", 64'(renamed.op), 64'(exp_out.op));
      check_value("renamed_o.prd", 64'(renamed.prd), 64'(exp_out.prd));
      check_value("renamed_o.prs1", 64'(renamed.prs1), 64'(exp_out.prs1));
      check_value("renamed_o.prs2", 64'(renamed.prs2), 64'(exp_out.prs2));
      check_value("renamed_o.old_prd", 64'(renamed.old_prd), 64'(exp_out.old_prd));
    end
  endtask

  task automatic check_reads();
    string port_name;
    for (int p = 0; p < READ_PORTS; p++) begin
      port_name = $sformatf("rd_data_o[%0d]", p);
      if (!rd_en[p]) begin
        // Disabled port reads zero
        check_value(port_name, 64'(rd_data[p]), 64'(0));
      end else if (wb_valid && (rd_addr[p] == wb.prd)) begin
        bypass_hits++;
        check_value(port_name, 64'(rd_data[p]), 64'(wb.data));
      end else if (written_m[rd_addr[p]]) begin
        check_value(port_name, 64'(rd_data[p]), 64'(regs_m[rd_addr[p]]));
      end
    end
  endtask

  // ==================================================
  // Stimulus and model update
  // ==================================================

  task automatic drive_inputs(input int ren_pct, input int commit_pct, input bit writer_only);
    if (hold_req) begin
      rename_valid = 1'b1;
    end else if (dir_pending) begin
      rename_valid = 1'b1;
      rename_req   = dir_req;
      dir_pending  = 1'b0;
    end else begin
      rename_valid = ($urandom_range(99, 0) < ren_pct);
      if (writer_only) begin
        rename_req.op = op_e'({1'b0, 1'($urandom())});
      end else begin
        rename_req.op = op_e'(2'($urandom()));
      end
      rename_req.rd  = AREG_W'($urandom());
      rename_req.rs1 = AREG_W'($urandom());
      rename_req.rs2 = AREG_W'($urandom());
    end
    // Retire the oldest superseded tag
    commit_valid = 1'b0;
    commit_prd   = '0;
    if ((commit_q.size() > 0) && ($urandom_range(99, 0) < commit_pct)) begin
      commit_valid = 1'b1;
      commit_prd   = commit_q.pop_front();
    end
    wb_valid = 1'($urandom());
    wb.prd   = PREG_W'($urandom());
    wb.data  = $urandom();
    rd_en    = READ_PORTS'($urandom());
    // Some reads aimed at the tag under writeback
    for (int p = 0; p < READ_PORTS; p++) begin
      rd_addr[p] = ($urandom_range(3, 0) == 0) ? wb.prd : PREG_W'($urandom());
    end
  endtask

  task automatic update_model(input logic exp_stall);
    logic accept;
    accept    = rename_valid && !exp_stall;
    exp_valid = accept;
    if (accept) begin
      exp_out.op   = rename_req.op;
      // Sources see the map before this update
      exp_out.prs1 = map_m[rename_req.rs1];
      exp_out.prs2 = map_m[rename_req.rs2];
      if (is_dest_op(rename_req.op)) begin
        exp_out.prd            = free_q.pop_front();
        exp_out.old_prd        = map_m[rename_req.rd];
        map_m[rename_req.rd]   = exp_out.prd;
        commit_q.push_back(exp_out.old_prd);
      end else begin
        exp_out.prd     = '0;
        exp_out.old_prd = '0;
      end
    end
    hold_req = rename_valid && exp_stall;
    // Pushed tag usable from the next cycle
    if (commit_valid) begin
      free_q.push_back(commit_prd);
    end
    if (wb_valid) begin
      regs_m[wb.prd]    = wb.data;
      written_m[wb.prd] = 1'b1;
    end
  endtask

  // One cycle: check, drive on the falling edge, check combinational outputs
  task automatic run_cycle(input int ren_pct, input int commit_pct, input bit writer_only);
    logic exp_stall;
    @(negedge clk);
    check_renamed_out();
    drive_inputs(ren_pct, commit_pct, writer_only);
    #1;
    exp_stall = is_dest_op(rename_req.op) && (free_q.size() == 0);
    check_value("rename_stall_o", 64'(rename_stall), 64'(exp_stall));
    // Stalls the DUT actually raised on a live request
    if (rename_valid && rename_stall) begin
      stall_cycles++;
    end
    check_reads();
    update_model(exp_stall);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    int guard;
    int stall_before;
    void'($urandom(SEED));
    clk          = 1'b0;
    rst_n        = 1'b0;
    rename_valid = 1'b0;
    rename_req   = '0;
    commit_valid = 1'b0;
    commit_prd   = '0;
    wb_valid     = 1'b0;
    wb           = '0;
    rd_en        = '0;
    rd_addr      = '0;
    errors       = 0;
    stall_cycles = 0;
    bypass_hits  = 0;
    exp_valid    = 1'b0;
    exp_out      = '0;
    hold_req     = 1'b0;
    dir_pending  = 1'b0;
    dir_req      = '0;
    // Identity map, upper half free
    for (int i = 0; i < ARCH_REG_NUM; i++) begin
      map_m[i] = PREG_W'(i);
      free_q.push_back(PREG_W'(i + ARCH_REG_NUM));
    end
    for (int i = 0; i < PHY_REG_NUM; i++) begin
      written_m[i] = 1'b0;
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Second writer reads the tag of the first
    queue_directed(OP_ALU, 5'd5, 5'd1, 5'd2);
    run_cycle(0, 0, 0);
    queue_directed(OP_ALU, 5'd6, 5'd5, 5'd5);
    run_cycle(0, 0, 0);
    queue_directed(OP_STORE, 5'd7, 5'd6, 5'd5);
    run_cycle(0, 0, 0);

    repeat (400) run_cycle(70, 30, 0);

    // Drain the free list with writers only
    guard = 0;
    while ((free_q.size() > 0) && (guard < 80)) begin
      run_cycle(100, 0, 1);
      guard++;
    end
    stall_before = stall_cycles;
    repeat (4) run_cycle(100, 0, 1);
    if (stall_cycles == stall_before) begin
      report_failure("rename_stall_o never rose while the free list was empty");
    end

    // Recycle tags, then allocate them in commit order
    repeat (8) run_cycle(0, 100, 1);
    repeat (8) run_cycle(100, 0, 1);

    repeat (200) run_cycle(70, 30, 0);
    @(negedge clk);
    check_renamed_out();
    if (bypass_hits == 0) begin
      report_failure("No read hit the tag under writeback in the same cycle");
    end

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Error: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== src.f ====
src/rename_pkg.sv
src/free_list.sv
src/rename_map.sv
src/rename_stage.sv
src/phys_reg_file.sv
src/rename_core.sv
sim/tb_rename_core.sv

// ==== src/free_list.sv ====
// Circular queue of unused physical tags, popped by rename and refilled by commit

`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              pop_i,
  input  logic              push_i,
  input  logic [PREG_W-1:0] push_tag_i,
  output logic [PREG_W-1:0] head_o,
  output logic              empty_o
);

  // Queue depth covers every physical tag
  localparam int FL_DEPTH = PHY_REG_NUM;
  // One extra bit so a full queue is representable
  localparam int CNT_W = PREG_W + 1;

  // ==================================================
  // State
  // ==================================================

  logic [FL_DEPTH-1:0][PREG_W-1:0] fl_q;
  logic [PREG_W-1:0]               head_q;
  logic [PREG_W-1:0]               tail_q;
  logic [CNT_W-1:0]                count_q;
  logic [CNT_W-1:0]                count_d;

  // Count follows both sides
  // Push and pop together leave it unchanged
  always_comb begin
    case ({push_i, pop_i})
      2'b10:   count_d = count_q + 1'b1;
      2'b01:   count_d = count_q - 1'b1;
      default: count_d = count_q;
    endcase
  end

  // ==================================================
  // Pointers and storage
  // ==================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Tags above the architectural range start free
      for (int i = 0; i < FL_DEPTH; i++) begin
        if (i < ARCH_REG_NUM) begin
          fl_q[i] <= PREG_W'(i + ARCH_REG_NUM);
        end else begin
          fl_q[i] <= '0;
        end
      end
      head_q  <= '0;
      // First empty slot sits right after the preloaded tags
      tail_q  <= PREG_W'(ARCH_REG_NUM);
      count_q <= CNT_W'(ARCH_REG_NUM);
    end else begin
      // Returned tag goes in at the tail
      if (push_i) begin
        fl_q[tail_q] <= push_tag_i;
        tail_q       <= tail_q + 1'b1;
      end
      // Allocation consumes the head entry
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_d;
    end
  end

  // ==================================================
  // Outputs
  // ==================================================

  // Next tag to hand out
  assign head_o = fl_q[head_q];

  // Pushed tag shows up here one cycle later
  assign empty_o = (count_q == '0);

endmodule

// ==== src/phys_reg_file.sv ====
// Physical register file with one writeback port and bypassed combinational read ports

`timescale 1ns/1ps

module phys_reg_file
  import rename_pkg::*;
#(
  parameter int READ_PORT_NUM = 2
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  // Writeback port
  input  logic                                       we_i,
  input  wb_t                                        wb_i,
  // Read ports
  input  logic [READ_PORT_NUM-1:0]                   re_i,
  input  logic [READ_PORT_NUM-1:0][PREG_W-1:0]       raddr_i,
  output logic [READ_PORT_NUM-1:0][DATA_WIDTH-1:0]   rdata_o
);

  // ==================================================
  // Storage
  // ==================================================

  // Contents carry no reset value
  logic [PHY_REG_NUM-1:0][DATA_WIDTH-1:0] regs_q;

  // Writes held off while reset is asserted
  always_ff @(posedge clk) begin
    if (rst_n && we_i) begin
      regs_q[wb_i.prd] <= wb_i.data;
    end
  end

  // ==================================================
  // Read ports
  // ==================================================

  always_comb begin
    for (int p = 0; p < READ_PORT_NUM; p++) begin
      if (!re_i[p]) begin
        // Idle port drives zero
        rdata_o[p] = '0;
      end else if (we_i && (raddr_i[p] == wb_i.prd)) begin
        // Same-cycle write forwarded
        rdata_o[p] = wb_i.data;
      end else begin
        rdata_o[p] = regs_q[raddr_i[p]];
      end
    end
  end

endmodule

// ==== src/rename_core.sv ====
// Top level of the rename and register-read slice, wiring free list, map, stage and register file

`timescale 1ns/1ps

module rename_core
  import rename_pkg::*;
#(
  parameter int READ_PORT_NUM = 2
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // Rename request
  input  logic                                     rename_valid_i,
  input  rename_req_t                              rename_req_i,
  output logic                                     rename_stall_o,
  // Renamed instruction
  output logic                                     renamed_valid_o,
  output renamed_t                                 renamed_o,
  // Retirement returns a tag
  input  logic                                     commit_valid_i,
  input  logic [PREG_W-1:0]                        commit_prd_i,
  // Writeback
  input  logic                                     wb_valid_i,
  input  wb_t                                      wb_i,
  // Operand reads
  input  logic [READ_PORT_NUM-1:0]                 rd_en_i,
  input  logic [READ_PORT_NUM-1:0][PREG_W-1:0]     rd_addr_i,
  output logic [READ_PORT_NUM-1:0][DATA_WIDTH-1:0] rd_data_o
);

  // ==================================================
  // Internal wires
  // ==================================================

  // Free list handshake
  logic              fl_pop;
  logic [PREG_W-1:0] fl_head;
  logic              fl_empty;

  // Map lookups
  logic [AREG_W-1:0] map_rs1;
  logic [AREG_W-1:0] map_rs2;
  logic [AREG_W-1:0] map_rd;
  logic [PREG_W-1:0] map_prs1;
  logic [PREG_W-1:0] map_prs2;
  logic [PREG_W-1:0] map_old_prd;

  // Map update
  logic              upd_en;
  logic [AREG_W-1:0] upd_areg;
  logic [PREG_W-1:0] upd_preg;

  // ==================================================
  // Instances
  // ==================================================

  // Commit pushes straight in
  free_list u_free_list (
    .clk        (clk),
    .rst_n      (rst_n),
    .pop_i      (fl_pop),
    .push_i     (commit_valid_i),
    .push_tag_i (commit_prd_i),
    .head_o     (fl_head),
    .empty_o    (fl_empty)
  );

  rename_map u_rename_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_i      (map_rs1),
    .rs2_i      (map_rs2),
    .rd_i       (map_rd),
    .prs1_o     (map_prs1),
    .prs2_o     (map_prs2),
    .old_prd_o  (map_old_prd),
    .upd_en_i   (upd_en),
    .upd_areg_i (upd_areg),
    .upd_preg_i (upd_preg)
  );

  // Combines free list head and map results
  rename_stage u_rename_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .rename_valid_i  (rename_valid_i),
    .rename_req_i    (rename_req_i),
    .rename_stall_o  (rename_stall_o),
    .renamed_valid_o (renamed_valid_o),
    .renamed_o       (renamed_o),
    .fl_head_i       (fl_head),
    .fl_empty_i      (fl_empty),
    .fl_pop_o        (fl_pop),
    .map_rs1_o       (map_rs1),
    .map_rs2_o       (map_rs2),
    .map_rd_o        (map_rd),
    .map_prs1_i      (map_prs1),
    .map_prs2_i      (map_prs2),
    .map_old_prd_i   (map_old_prd),
    .upd_en_o        (upd_en),
    .upd_areg_o      (upd_areg),
    .upd_preg_o      (upd_preg)
  );

  // Operand storage with writeback bypass
  phys_reg_file #(
    .READ_PORT_NUM (READ_PORT_NUM)
  ) u_phys_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .we_i    (wb_valid_i),
    .wb_i    (wb_i),
    .re_i    (rd_en_i),
    .raddr_i (rd_addr_i),
    .rdata_o (rd_data_o)
  );

endmodule

// ==== src/rename_map.sv ====
// Register alias table mapping architectural registers to physical tags for the rename stage

`timescale 1ns/1ps

module rename_map
  import rename_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // Lookup addresses
  input  logic [AREG_W-1:0] rs1_i,
  input  logic [AREG_W-1:0] rs2_i,
  input  logic [AREG_W-1:0] rd_i,
  // Current mappings
  output logic [PREG_W-1:0] prs1_o,
  output logic [PREG_W-1:0] prs2_o,
  output logic [PREG_W-1:0] old_prd_o,
  // Single update port
  input  logic              upd_en_i,
  input  logic [AREG_W-1:0] upd_areg_i,
  input  logic [PREG_W-1:0] upd_preg_i
);

  // ==================================================
  // Map table
  // ==================================================

  // One physical tag per architectural register
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] map_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping out of reset
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= PREG_W'(i);
      end
    end else if (upd_en_i) begin
      // New mapping visible from the next cycle
      map_q[upd_areg_i] <= upd_preg_i;
    end
  end

  // ==================================================
  // Lookups
  // ==================================================

  // Source operands
  assign prs1_o = map_q[rs1_i];
  assign prs2_o = map_q[rs2_i];

  // Previous owner of rd, released at retirement
  assign old_prd_o = map_q[rd_i];

endmodule

// ==== src/rename_pkg.sv ====
// Shared sizes, opcode encoding and bus structs for the rename slice, imported by every module

package rename_pkg;

  // ==================================================
  // Size constants
  // ==================================================

  // Architectural and physical register counts
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;

  // Tag widths
  localparam int AREG_W = 5;
  localparam int PREG_W = 6;

  // Register value width
  localparam int DATA_WIDTH = 32;

  // ==================================================
  // Opcodes and buses
  // ==================================================

  // Two-bit opcode class
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_BRANCH = 2'd3
  } op_e;

  // Incoming rename request, 17 bits
  typedef struct packed {
    op_e               op;
    logic [AREG_W-1:0] rd;
    logic [AREG_W-1:0] rs1;
    logic [AREG_W-1:0] rs2;
  } rename_req_t;

  // Renamed instruction, 26 bits
  // prd and old_prd stay zero without a destination
  typedef struct packed {
    op_e               op;
    logic [PREG_W-1:0] prd;
    logic [PREG_W-1:0] prs1;
    logic [PREG_W-1:0] prs2;
    logic [PREG_W-1:0] old_prd;
  } renamed_t;

  // Writeback into the register file, 38 bits
  typedef struct packed {
    logic [PREG_W-1:0]     prd;
    logic [DATA_WIDTH-1:0] data;
  } wb_t;

  // ALU and load results land in rd
  function automatic logic op_writes_rd(op_e op);
    logic writes;
    case (op)
      OP_ALU, OP_LOAD: writes = 1'b1;
      default:         writes = 1'b0;
    endcase
    return writes;
  endfunction

endpackage

// ==== src/rename_stage.sv ====
// Rename stage that allocates a free tag, updates the map and registers the renamed instruction

`timescale 1ns/1ps

module rename_stage
  import rename_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  // Request side
  input  logic              rename_valid_i,
  input  rename_req_t       rename_req_i,
  output logic              rename_stall_o,
  // Renamed output
  output logic              renamed_valid_o,
  output renamed_t          renamed_o,
  // Free list
  input  logic [PREG_W-1:0] fl_head_i,
  input  logic              fl_empty_i,
  output logic              fl_pop_o,
  // Map lookups
  output logic [AREG_W-1:0] map_rs1_o,
  output logic [AREG_W-1:0] map_rs2_o,
  output logic [AREG_W-1:0] map_rd_o,
  input  logic [PREG_W-1:0] map_prs1_i,
  input  logic [PREG_W-1:0] map_prs2_i,
  input  logic [PREG_W-1:0] map_old_prd_i,
  // Map update
  output logic              upd_en_o,
  output logic [AREG_W-1:0] upd_areg_o,
  output logic [PREG_W-1:0] upd_preg_o
);

  // ==================================================
  // Accept and allocate
  // ==================================================

  logic     writes_rd;
  logic     accept;
  logic     alloc;
  renamed_t renamed_d;
  logic     renamed_valid_q;
  renamed_t renamed_q;

  // Only destination writers need a tag
  assign writes_rd = op_writes_rd(rename_req_i.op);

  // Stall on a writer with nothing left to allocate
  assign rename_stall_o = writes_rd && fl_empty_i;

  assign accept = rename_valid_i && !rename_stall_o;
  assign alloc  = accept && writes_rd;

  // Head tag consumed at the accepting edge
  assign fl_pop_o = alloc;

  // Lookups straight from the request
  assign map_rs1_o = rename_req_i.rs1;
  assign map_rs2_o = rename_req_i.rs2;
  assign map_rd_o  = rename_req_i.rd;

  // rd now points at the fresh tag
  assign upd_en_o   = alloc;
  assign upd_areg_o = rename_req_i.rd;
  assign upd_preg_o = fl_head_i;

  // ==================================================
  // Renamed instruction
  // ==================================================

  always_comb begin
    renamed_d.op   = rename_req_i.op;
    renamed_d.prs1 = map_prs1_i;
    renamed_d.prs2 = map_prs2_i;
    // Store and branch carry zero destination tags
    renamed_d.prd     = writes_rd ? fl_head_i : '0;
    renamed_d.old_prd = writes_rd ? map_old_prd_i : '0;
  end

  // Valid pulse one cycle after acceptance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      renamed_valid_q <= 1'b0;
    end else begin
      renamed_valid_q <= accept;
    end
  end

  // Payload only loads on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      renamed_q <= renamed_d;
    end
  end

  assign renamed_valid_o = renamed_valid_q;
  assign renamed_o       = renamed_q;

endmodule
